// File: bench/dmem_array_tb.sv
`timescale 1ns/1ps

module dmem_array_tb;

	localparam int BANK_COUNT   = 18;
	localparam int DEPTH        = 2 ** dmem_pkg::BANK_ADDR_W;
	localparam int RANDOM_COUNT = 400;
	// Roughly four times the stimulus length
	localparam int CYCLE_LIMIT  = 2000;

	typedef struct packed {
		logic                   rd;
		dmem_pkg::bank_sel_t    sel;
		dmem_pkg::bank_addr_t   addr;
		dmem_pkg::data_word_t   wdata;
	} request_t;

	logic                   clk;
	logic                   rst_n;
	logic                   rd;
	dmem_pkg::bank_sel_t    sel;
	dmem_pkg::bank_addr_t   addr;
	dmem_pkg::data_word_t   wdata;
	dmem_pkg::data_word_t   rdata;

	// Reference state
	dmem_pkg::data_word_t   shadow_mem [BANK_COUNT][DEPTH];
	logic                   shadow_valid [BANK_COUNT][DEPTH];
	request_t               history [$];
	dmem_pkg::data_word_t   exp_rdata;
	logic                   exp_known;

	logic                   reset_hold;
	integer                 seed;
	int                     cycles;
	int                     checks;
	int                     errors;

	dmem_array #(
		.BANK_COUNT (BANK_COUNT)
	) DUT (
		.clk   (clk),
		.rst_n (rst_n),
		.rd    (rd),
		.sel   (sel),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata)
	);

	always #50 clk = ~clk;

	// --------------------
	// Timeout
	// --------------------

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// --------------------
	// Reference model
	// --------------------

	// Top bit tells whether the word is known
	function automatic logic [dmem_pkg::DATA_W:0] expected_rdata(
		input request_t              req,
		input dmem_pkg::data_word_t  last_word,
		input logic                  last_known
	);
		logic [dmem_pkg::DATA_W:0] result;
		result = {last_known, last_word};
		if (req.rd && req.sel < BANK_COUNT) begin
			result = {shadow_valid[req.sel][req.addr], shadow_mem[req.sel][req.addr]};
		end
		return result;
	endfunction

	// Oldest request leaves the pipeline
	task automatic retire_request();
		request_t                   req;
		logic [dmem_pkg::DATA_W:0]  result;
		req = history.pop_front();
		result = expected_rdata(req, exp_rdata, exp_known);
		exp_known = result[dmem_pkg::DATA_W];
		exp_rdata = result[dmem_pkg::DATA_W-1:0];
		if (!req.rd && req.sel < BANK_COUNT) begin
			shadow_mem[req.sel][req.addr] = req.wdata;
			shadow_valid[req.sel][req.addr] = 1'b1;
		end
	endtask

	task automatic check_value(
		input string                 name,
		input dmem_pkg::data_word_t  expected,
		input dmem_pkg::data_word_t  actual
	);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// Compare at the falling edge, three slots behind the stimulus
	initial begin
		logic edge_rst;
		forever begin
			@(posedge clk);
			edge_rst = rst_n;
			@(negedge clk);
			if (history.size() >= 4) begin
				retire_request();
			end
			if (!edge_rst) begin
				exp_rdata = '0;
				exp_known = 1'b1;
			end
			if (exp_known) begin
				check_value("rdata", exp_rdata, rdata);
			end
		end
	end

	// --------------------
	// Stimulus
	// --------------------

	// In reset the pipeline sees a read of bank 31
	task automatic drive_request(
		input logic                  rd_val,
		input int                    sel_val,
		input int                    addr_val,
		input dmem_pkg::data_word_t  wdata_val
	);
		request_t req;
		@(posedge clk);
		#10;
		rst_n = !reset_hold;
		rd    = rd_val;
		sel   = dmem_pkg::bank_sel_t'(sel_val);
		addr  = dmem_pkg::bank_addr_t'(addr_val);
		wdata = wdata_val;
		req.rd    = rst_n ? rd : 1'b1;
		req.sel   = rst_n ? sel : '1;
		req.addr  = addr;
		req.wdata = wdata;
		history.push_back(req);
	endtask

	initial begin
		int bank;
		int idx;
		int entry;
		int r_sel;
		int r_addr;
		int pool [$];

		clk        = 1'b0;
		rst_n      = 1'b0;
		rd         = 1'b1;
		sel        = 5'd31;
		addr       = '0;
		wdata      = '0;
		reset_hold = 1'b1;
		seed       = 32'h6ece;
		cycles     = 0;
		checks     = 0;
		errors     = 0;
		exp_rdata  = '0;
		exp_known  = 1'b1;
		for (bank = 0; bank < BANK_COUNT; bank++) begin
			for (idx = 0; idx < DEPTH; idx++) begin
				shadow_valid[bank][idx] = 1'b0;
			end
		end

		// Reset and its exit, reads to a missing bank
		repeat (7) drive_request(1'b1, 31, 0, '0);
		reset_hold = 1'b0;
		repeat (4) drive_request(1'b1, 31, 0, '0);

		// Same address in every bank
		for (bank = 0; bank < BANK_COUNT; bank++) begin
			drive_request(1'b0, bank, 10'h155, 32'hc0de_0000 | bank);
		end
		for (bank = 0; bank < BANK_COUNT; bank++) begin
			drive_request(1'b1, bank, 10'h155, '0);
		end

		// Back-to-back reads across banks
		for (idx = 0; idx < 8; idx++) begin
			drive_request(1'b0, (idx * 5) % BANK_COUNT, idx * 97 + 3, $random(seed));
		end
		for (idx = 7; idx >= 0; idx--) begin
			drive_request(1'b1, (idx * 5) % BANK_COUNT, idx * 97 + 3, '0);
		end

		// Read right behind a write
		for (idx = 0; idx < 6; idx++) begin
			drive_request(1'b0, 17 - idx * 3, DEPTH - 1 - idx, $random(seed));
			drive_request(1'b1, 17 - idx * 3, DEPTH - 1 - idx, '0);
		end

		// Output holds over writes and bad selects
		drive_request(1'b1, 4, 10'h155, '0);
		for (idx = 0; idx < 6; idx++) begin
			drive_request(1'b0, idx, 10'h200 + idx, $random(seed));
		end
		drive_request(1'b1, 18, 10'h155, '0);
		drive_request(1'b1, 24, 0, '0);
		drive_request(1'b1, 31, 0, '0);
		drive_request(1'b0, 4, 10'h155, 32'hdead_beef);
		drive_request(1'b1, 4, 10'h155, '0);

		// Random mix, reads lean on written words
		for (idx = 0; idx < RANDOM_COUNT; idx++) begin
			r_sel  = {$random(seed)} % BANK_COUNT;
			r_addr = {$random(seed)} % DEPTH;
			if ($random(seed) & 1) begin
				if (pool.size() > 0 && ($random(seed) & 1)) begin
					entry  = pool[{$random(seed)} % pool.size()];
					r_sel  = entry / DEPTH;
					r_addr = entry % DEPTH;
				end
				drive_request(1'b1, r_sel, r_addr, '0);
			end else begin
				pool.push_back(r_sel * DEPTH + r_addr);
				drive_request(1'b0, r_sel, r_addr, $random(seed));
			end
		end

		// Drain the pipeline
		repeat (4) drive_request(1'b1, 31, 0, '0);
		@(negedge clk);
		#1;

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (checks == 0) begin
			$display("No rdata value was ever compared");
		end
		if (errors == 0 && checks > 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: bench/dmem_request_properties.sv
`timescale 1ns/1ps

module dmem_request_properties #(
	parameter int BANK_COUNT = 18
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   rd_q,
	input  logic [BANK_COUNT-1:0]  write_en
);

	// --------------------
	// Write enable decode
	// --------------------

	// At most one bank written per cycle
	write_en_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(write_en)
	) else $error("write_en enables more than one bank");

	// A registered read never writes
	read_no_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd_q |-> (write_en == '0)
	) else $error("write_en set while rd_q marks a read");

	// Reset clears the enables
	reset_no_write: assert property (
		@(posedge clk)
		!rst_n |=> (write_en == '0)
	) else $error("write_en not cleared by reset");

endmodule

bind dmem_request_stage dmem_request_properties #(
	.BANK_COUNT (BANK_COUNT)
) u_request_properties (
	.clk      (clk),
	.rst_n    (rst_n),
	.rd_q     (rd_q),
	.write_en (write_en)
);

// File: compile.f
source/dmem_pkg.sv
source/dmem_request_stage.sv
source/dmem_bank.sv
source/dmem_read_select.sv
source/dmem_array.sv
bench/dmem_request_properties.sv
bench/dmem_array_tb.sv

// File: source/dmem_array.sv
`timescale 1ns/1ps

module dmem_array #(
	parameter int BANK_COUNT = 18
) (
	input  logic                   clk,
	input  logic                   rst_n,

	// Request, 1 on rd means read and 0 means write
	input  logic                   rd,
	input  dmem_pkg::bank_sel_t    sel,
	input  dmem_pkg::bank_addr_t   addr,
	input  dmem_pkg::data_word_t   wdata,

	// Read word, three cycles after the request
	output dmem_pkg::data_word_t   rdata
);

	// --------------------
	// Internal wiring
	// --------------------

	dmem_pkg::bank_addr_t                   addr_q;
	dmem_pkg::data_word_t                   wdata_q;
	logic                                   rd_q;
	dmem_pkg::bank_sel_t                    sel_q;
	logic [BANK_COUNT-1:0]                  write_en;
	dmem_pkg::data_word_t [BANK_COUNT-1:0]  bank_rdata;

	// --------------------
	// Stage 1
	// --------------------

	dmem_request_stage #(
		.BANK_COUNT (BANK_COUNT)
	) u_request_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd       (rd),
		.sel      (sel),
		.addr     (addr),
		.wdata    (wdata),
		.addr_q   (addr_q),
		.wdata_q  (wdata_q),
		.rd_q     (rd_q),
		.sel_q    (sel_q),
		.write_en (write_en)
	);

	// --------------------
	// Memory banks
	// --------------------

	// All banks see the same address and data, only the enable differs
	for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank
		dmem_bank u_bank (
			.clk      (clk),
			.write_en (write_en[i]),
			.addr     (addr_q),
			.wdata    (wdata_q),
			.rdata    (bank_rdata[i])
		);
	end

	// --------------------
	// Stages 2 and 3
	// --------------------

	dmem_read_select #(
		.BANK_COUNT (BANK_COUNT)
	) u_read_select (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_q       (rd_q),
		.sel_q      (sel_q),
		.bank_rdata (bank_rdata),
		.rdata      (rdata)
	);

endmodule

// File: source/dmem_bank.sv
`timescale 1ns/1ps

module dmem_bank (
	input  logic                   clk,

	// Write strobe from the request decode
	input  logic                   write_en,

	// Shared registered address and data
	input  dmem_pkg::bank_addr_t   addr,
	input  dmem_pkg::data_word_t   wdata,

	// Registered read word
	output dmem_pkg::data_word_t   rdata
);

	localparam int DEPTH = 2 ** dmem_pkg::BANK_ADDR_W;

	// Storage
	dmem_pkg::data_word_t mem [0:DEPTH-1];

	// --------------------
	// Write port
	// --------------------

	always_ff @(posedge clk) begin
		if (write_en) begin
			mem[addr] <= wdata;
		end
	end

	// --------------------
	// Read port
	// --------------------

	// Read before write, the old word comes out on a same-address write
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

// File: source/dmem_pkg.sv
package dmem_pkg;

	// --------------------
	// Widths
	// --------------------

	// One memory word
	parameter int DATA_W = 32;

	// Word address inside one bank, 1024 words
	parameter int BANK_ADDR_W = 10;

	// Bank select, room for up to 32 banks
	parameter int SEL_W = 5;

	// --------------------
	// Vector types
	// --------------------

	// Write data, bank outputs and read output
	typedef logic [DATA_W-1:0] data_word_t;

	// Bank-local address
	typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

	// Bank select
	typedef logic [SEL_W-1:0] bank_sel_t;

endpackage

// File: source/dmem_read_select.sv
`timescale 1ns/1ps

module dmem_read_select #(
	parameter int BANK_COUNT = 18
) (
	input  logic                                    clk,
	input  logic                                    rst_n,

	// Control from the request stage
	input  logic                                    rd_q,
	input  dmem_pkg::bank_sel_t                     sel_q,

	// Read words of all banks
	input  dmem_pkg::data_word_t [BANK_COUNT-1:0]   bank_rdata,

	// Registered read result
	output dmem_pkg::data_word_t                    rdata
);

	logic                  rd_qq;
	dmem_pkg::bank_sel_t   sel_qq;
	logic                  sel_in_range;
	logic                  capture;

	// --------------------
	// Stage 2 registers
	// --------------------

	// Lines the control up with the bank read words
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_qq  <= 1'b1;
			sel_qq <= '1;
		end else begin
			rd_qq  <= rd_q;
			sel_qq <= sel_q;
		end
	end

	// --------------------
	// Stage 3 output
	// --------------------

	assign sel_in_range = (sel_qq < BANK_COUNT);

	// Only a read to an existing bank updates the output
	assign capture = rd_qq && sel_in_range;

	// Holds the last read word on writes and bad selects
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (capture) begin
			rdata <= bank_rdata[sel_qq];
		end
	end

endmodule

// File: source/dmem_request_stage.sv
`timescale 1ns/1ps

module dmem_request_stage #(
	parameter int BANK_COUNT = 18
) (
	input  logic                   clk,
	input  logic                   rst_n,

	// Request from the core, sampled every cycle
	input  logic                   rd,
	input  dmem_pkg::bank_sel_t    sel,
	input  dmem_pkg::bank_addr_t   addr,
	input  dmem_pkg::data_word_t   wdata,

	// Registered request, shared by all banks
	output dmem_pkg::bank_addr_t   addr_q,
	output dmem_pkg::data_word_t   wdata_q,

	// Registered control, on to the read select
	output logic                   rd_q,
	output dmem_pkg::bank_sel_t    sel_q,

	// One enable per bank
	output logic [BANK_COUNT-1:0]  write_en
);

	logic [BANK_COUNT-1:0] write_en_d;

	// --------------------
	// Write enable decode
	// --------------------

	// One-hot on a write to an existing bank, all zero otherwise
	always_comb begin
		write_en_d = '0;
		if (!rd) begin
			for (int i = 0; i < BANK_COUNT; i++) begin
				if (sel == dmem_pkg::bank_sel_t'(i)) begin
					write_en_d[i] = 1'b1;
				end
			end
		end
	end

	// --------------------
	// Stage 1 registers
	// --------------------

	// Reset looks like a read of a missing bank, so nothing is written or captured
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_q     <= 1'b1;
			sel_q    <= '1;
			write_en <= '0;
		end else begin
			rd_q     <= rd;
			sel_q    <= sel;
			write_en <= write_en_d;
		end
	end

	// Address and write data
	always_ff @(posedge clk) begin
		addr_q  <= addr;
		wdata_q <= wdata;
	end

endmodule
